/* design/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int REGNM_W = 5;

    // architectural register file size
    localparam int REG_COUNT = 2 ** REGNM_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // x0 is hardwired, never renamed
    typedef logic [REGNM_W-1:0] regnm_t;

    // kind of instruction held by a reorder entry
    typedef enum logic [1:0] {
        OP_ALU    = 2'd0,
        OP_BRANCH = 2'd1,
        OP_STORE  = 2'd2
    } op_kind_t;

endpackage

`default_nettype wire

/* design/rob_if.sv */
`timescale 1ns/1ns
`default_nettype none

// result writeback from ex or lsb
interface rob_wb_if #(
    parameter int TAG_W = 4
);
    logic                en;
    logic [TAG_W-1:0]    tag;
    rob_pkg::data_t      data;
    logic                taken;
    rob_pkg::addr_t      target;

    modport sink (
        input en,
        input tag,
        input data,
        input taken,
        input target
    );
endinterface

// entry allocation at dispatch
interface rob_alloc_if #(
    parameter int TAG_W = 4
);
    logic                en;
    logic [TAG_W-1:0]    tag;
    rob_pkg::regnm_t     regnm;
    rob_pkg::op_kind_t   kind;
    logic                predicted;

    // grant and tail tag come from the control block
    modport ctrl (
        output en,
        output tag
    );

    modport sink (
        input en,
        input tag,
        input regnm,
        input kind,
        input predicted
    );
endinterface

`default_nettype wire

/* design/rob_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module rob_ctrl #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                            clk,
    input  wire                            rst,
    rob_alloc_if.ctrl                      alloc,
    input  logic                           dispatch_valid,
    input  logic                           head_done,
    input  rob_pkg::op_kind_t              head_kind,
    input  logic                           head_mispredict,
    input  rob_pkg::regnm_t                head_regnm,
    input  rob_pkg::data_t                 head_data,
    input  rob_pkg::addr_t                 head_target,
    output logic                           retire,
    output logic [$clog2(ROB_DEPTH)-1:0]   retire_tag,
    output logic                           flush,
    output logic                           full,
    output logic                           rf_we,
    output rob_pkg::regnm_t                rf_regnm,
    output rob_pkg::data_t                 rf_data,
    output logic [$clog2(ROB_DEPTH)-1:0]   rf_tag,
    output logic                           store_commit_en,
    output logic [$clog2(ROB_DEPTH)-1:0]   store_commit_tag,
    output logic                           redirect_en,
    output rob_pkg::addr_t                 redirect_pc
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam logic [TAG_W:0] FULL_COUNT = (TAG_W + 1)'(ROB_DEPTH);

    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [TAG_W:0]   count;
    logic             head_valid;
    logic             head_store;

    assign full       = (count == FULL_COUNT);
    assign head_valid = (count != '0);
    assign head_store = (head_kind == rob_pkg::OP_STORE);

    assign alloc.en  = dispatch_valid && !full;
    assign alloc.tag = tail;

    // stores leave at the head without waiting for a result
    assign retire     = head_valid && (head_store || head_done);
    assign retire_tag = head;
    assign flush      = retire && !head_store && head_mispredict;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // restart right after the mispredicted branch
            head  <= head + 1'b1;
            tail  <= head + 1'b1;
            count <= '0;
        end else begin
            if (alloc.en) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({alloc.en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // commit strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            rf_we           <= 1'b0;
            store_commit_en <= 1'b0;
            redirect_en     <= 1'b0;
        end else begin
            rf_we           <= retire && !head_store;
            store_commit_en <= retire && head_store;
            redirect_en     <= flush;
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            rf_regnm         <= head_regnm;
            rf_data          <= head_data;
            rf_tag           <= head;
            store_commit_tag <= head;
            redirect_pc      <= head_target;
        end
    end

endmodule

`default_nettype wire

/* design/rob_entry_file.sv */
`timescale 1ns/1ns
`default_nettype none

module rob_entry_file #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                            clk,
    input  wire                            rst,
    rob_alloc_if.sink                      alloc,
    rob_wb_if.sink                         ex_wb,
    rob_wb_if.sink                         lsb_wb,
    input  logic                           retire,
    input  logic [$clog2(ROB_DEPTH)-1:0]   retire_tag,
    input  logic                           flush,
    input  logic [$clog2(ROB_DEPTH)-1:0]   head_tag,
    output logic                           head_done,
    output rob_pkg::op_kind_t              head_kind,
    output logic                           head_mispredict,
    output rob_pkg::regnm_t                head_regnm,
    output rob_pkg::data_t                 head_data,
    output rob_pkg::addr_t                 head_target
);

    // entry state
    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] done;

    // entry payload
    rob_pkg::regnm_t      regnm_q  [ROB_DEPTH];
    rob_pkg::op_kind_t    kind_q   [ROB_DEPTH];
    rob_pkg::data_t       data_q   [ROB_DEPTH];
    rob_pkg::addr_t       target_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] predicted_q;
    logic [ROB_DEPTH-1:0] taken_q;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
            done  <= '0;
        end else begin
            if (alloc.en) begin
                valid[alloc.tag] <= 1'b1;
                done[alloc.tag]  <= 1'b0;
            end
            // late results for a squashed slot are dropped
            if (ex_wb.en && valid[ex_wb.tag]) begin
                done[ex_wb.tag] <= 1'b1;
            end
            if (lsb_wb.en && valid[lsb_wb.tag]) begin
                done[lsb_wb.tag] <= 1'b1;
            end
            if (retire) begin
                valid[retire_tag] <= 1'b0;
                done[retire_tag]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.en) begin
            regnm_q[alloc.tag]     <= alloc.regnm;
            kind_q[alloc.tag]      <= alloc.kind;
            predicted_q[alloc.tag] <= alloc.predicted;
        end
        if (ex_wb.en) begin
            data_q[ex_wb.tag]   <= ex_wb.data;
            taken_q[ex_wb.tag]  <= ex_wb.taken;
            target_q[ex_wb.tag] <= ex_wb.target;
        end
        if (lsb_wb.en) begin
            data_q[lsb_wb.tag]   <= lsb_wb.data;
            taken_q[lsb_wb.tag]  <= lsb_wb.taken;
            target_q[lsb_wb.tag] <= lsb_wb.target;
        end
    end

    // head view for the control block
    assign head_done   = done[head_tag];
    assign head_kind   = kind_q[head_tag];
    assign head_regnm  = regnm_q[head_tag];
    assign head_data   = data_q[head_tag];
    assign head_target = target_q[head_tag];

    // only branches can mispredict
    assign head_mispredict = (kind_q[head_tag] == rob_pkg::OP_BRANCH)
                             && (predicted_q[head_tag] != taken_q[head_tag]);

endmodule

`default_nettype wire

/* design/rename_table.sv */
`timescale 1ns/1ns
`default_nettype none

module rename_table #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                            clk,
    input  wire                            rst,
    rob_alloc_if.sink                      alloc,
    input  logic                           retire,
    input  logic [$clog2(ROB_DEPTH)-1:0]   retire_tag,
    input  rob_pkg::regnm_t                retire_regnm,
    input  logic                           flush,
    input  rob_pkg::regnm_t                src_regnm,
    output logic                           src_busy,
    output logic [$clog2(ROB_DEPTH)-1:0]   src_tag
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [rob_pkg::REG_COUNT-1:0] busy;
    logic [TAG_W-1:0]              tag_q [rob_pkg::REG_COUNT];
    logic                          renames;
    logic                          producer_leaves;

    // x0 never gets a producer
    assign renames = alloc.en && (alloc.regnm != '0);

    // an older producer retiring leaves the newer mapping alone
    assign producer_leaves = retire && busy[retire_regnm]
                             && (tag_q[retire_regnm] == retire_tag);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            if (producer_leaves) begin
                busy[retire_regnm] <= 1'b0;
            end
            // a new producer wins over a retiring one
            if (renames) begin
                busy[alloc.regnm] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (renames) begin
            tag_q[alloc.regnm] <= alloc.tag;
        end
    end

    assign src_busy = busy[src_regnm];
    assign src_tag  = tag_q[src_regnm];

endmodule

`default_nettype wire

/* design/rob_top.sv */
`timescale 1ns/1ns
`default_nettype none

module rob_top #(
    parameter int ROB_DEPTH = 16
) (
    input  wire                            clk,
    input  wire                            rst,
    // dispatch
    input  logic                           dispatch_valid,
    input  rob_pkg::regnm_t                dispatch_regnm,
    input  rob_pkg::op_kind_t              dispatch_kind,
    input  logic                           dispatch_predicted,
    output logic                           dispatch_en,
    output logic [$clog2(ROB_DEPTH)-1:0]   dispatch_tag,
    output logic                           full,
    // execute writeback
    input  logic                           ex_en,
    input  logic [$clog2(ROB_DEPTH)-1:0]   ex_tag,
    input  rob_pkg::data_t                 ex_data,
    input  logic                           ex_taken,
    input  rob_pkg::addr_t                 ex_target,
    // load/store buffer writeback
    input  logic                           lsb_en,
    input  logic [$clog2(ROB_DEPTH)-1:0]   lsb_tag,
    input  rob_pkg::data_t                 lsb_data,
    // rename lookup
    input  rob_pkg::regnm_t                src_regnm,
    output logic                           src_busy,
    output logic [$clog2(ROB_DEPTH)-1:0]   src_tag,
    // commit
    output logic                           rf_we,
    output rob_pkg::regnm_t                rf_regnm,
    output rob_pkg::data_t                 rf_data,
    output logic [$clog2(ROB_DEPTH)-1:0]   rf_tag,
    output logic                           store_commit_en,
    output logic [$clog2(ROB_DEPTH)-1:0]   store_commit_tag,
    output logic                           redirect_en,
    output rob_pkg::addr_t                 redirect_pc
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic              head_done;
    rob_pkg::op_kind_t head_kind;
    logic              head_mispredict;
    rob_pkg::regnm_t   head_regnm;
    rob_pkg::data_t    head_data;
    rob_pkg::addr_t    head_target;
    logic              retire;
    logic [TAG_W-1:0]  retire_tag;
    logic              flush;

    rob_alloc_if #(.TAG_W(TAG_W)) alloc_bus ();
    rob_wb_if    #(.TAG_W(TAG_W)) ex_wb ();
    rob_wb_if    #(.TAG_W(TAG_W)) lsb_wb ();

    assign alloc_bus.regnm     = dispatch_regnm;
    assign alloc_bus.kind      = dispatch_kind;
    assign alloc_bus.predicted = dispatch_predicted;
    assign dispatch_en         = alloc_bus.en;
    assign dispatch_tag        = alloc_bus.tag;

    assign ex_wb.en     = ex_en;
    assign ex_wb.tag    = ex_tag;
    assign ex_wb.data   = ex_data;
    assign ex_wb.taken  = ex_taken;
    assign ex_wb.target = ex_target;

    // loads never branch
    assign lsb_wb.en     = lsb_en;
    assign lsb_wb.tag    = lsb_tag;
    assign lsb_wb.data   = lsb_data;
    assign lsb_wb.taken  = 1'b0;
    assign lsb_wb.target = '0;

    rob_ctrl #(.ROB_DEPTH(ROB_DEPTH)) rob_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .alloc            (alloc_bus.ctrl),
        .dispatch_valid   (dispatch_valid),
        .head_done        (head_done),
        .head_kind        (head_kind),
        .head_mispredict  (head_mispredict),
        .head_regnm       (head_regnm),
        .head_data        (head_data),
        .head_target      (head_target),
        .retire           (retire),
        .retire_tag       (retire_tag),
        .flush            (flush),
        .full             (full),
        .rf_we            (rf_we),
        .rf_regnm         (rf_regnm),
        .rf_data          (rf_data),
        .rf_tag           (rf_tag),
        .store_commit_en  (store_commit_en),
        .store_commit_tag (store_commit_tag),
        .redirect_en      (redirect_en),
        .redirect_pc      (redirect_pc)
    );

    rob_entry_file #(.ROB_DEPTH(ROB_DEPTH)) rob_entry_file_i (
        .clk             (clk),
        .rst             (rst),
        .alloc           (alloc_bus.sink),
        .ex_wb           (ex_wb.sink),
        .lsb_wb          (lsb_wb.sink),
        .retire          (retire),
        .retire_tag      (retire_tag),
        .flush           (flush),
        .head_tag        (retire_tag),
        .head_done       (head_done),
        .head_kind       (head_kind),
        .head_mispredict (head_mispredict),
        .head_regnm      (head_regnm),
        .head_data       (head_data),
        .head_target     (head_target)
    );

    rename_table #(.ROB_DEPTH(ROB_DEPTH)) rename_table_i (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc_bus.sink),
        .retire       (retire),
        .retire_tag   (retire_tag),
        .retire_regnm (head_regnm),
        .flush        (flush),
        .src_regnm    (src_regnm),
        .src_busy     (src_busy),
        .src_tag      (src_tag)
    );

endmodule

`default_nettype wire

/* test/rob_model.svh */
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH
`default_nettype none

// one in-flight entry as the testbench expects it
typedef struct packed {
    logic [TAG_W-1:0]  tag;
    rob_pkg::regnm_t   regnm;
    rob_pkg::op_kind_t kind;
    logic              predicted;
    logic              taken;
    logic              done;
    rob_pkg::data_t    data;
    rob_pkg::addr_t    target;
} exp_entry_t;

// oldest entry at the front
exp_entry_t       pending_q[$];
logic             busy_m  [rob_pkg::REG_COUNT];
logic [TAG_W-1:0] owner_m [rob_pkg::REG_COUNT];
logic [TAG_W-1:0] next_tag;

function automatic void clear_rename();
    for (int r = 0; r < rob_pkg::REG_COUNT; r++) begin
        busy_m[r]  = 1'b0;
        owner_m[r] = '0;
    end
endfunction

function automatic void reset_model();
    pending_q.delete();
    clear_rename();
    next_tag = '0;
endfunction

function automatic void record_dispatch(rob_pkg::regnm_t regnm, rob_pkg::op_kind_t kind,
                                        logic predicted);
    exp_entry_t e;
    e           = '0;
    e.tag       = next_tag;
    e.regnm     = regnm;
    e.kind      = kind;
    e.predicted = predicted;
    pending_q.push_back(e);
    // x0 has no producer
    if (regnm != '0) begin
        busy_m[regnm]  = 1'b1;
        owner_m[regnm] = next_tag;
    end
    next_tag = next_tag + 1'b1;
endfunction

function automatic void record_result(int idx, rob_pkg::data_t data, logic taken,
                                      rob_pkg::addr_t target);
    pending_q[idx].done   = 1'b1;
    pending_q[idx].data   = data;
    pending_q[idx].taken  = taken;
    pending_q[idx].target = target;
endfunction

// a branch redirects when its outcome differs from the prediction
function automatic logic expect_redirect(exp_entry_t e);
    return (e.kind == rob_pkg::OP_BRANCH) && (e.taken != e.predicted);
endfunction

function automatic void retire_entry(exp_entry_t e);
    if (busy_m[e.regnm] && owner_m[e.regnm] == e.tag) begin
        busy_m[e.regnm] = 1'b0;
    end
    if (expect_redirect(e)) begin
        // everything younger is squashed
        pending_q.delete();
        clear_rename();
        next_tag = e.tag + 1'b1;
    end
endfunction

`default_nettype wire
`endif

/* test/tb_rob.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rob;

    localparam int ROB_DEPTH   = 16;
    localparam int TAG_W       = $clog2(ROB_DEPTH);
    localparam int RUN_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 500;

    logic              clk;
    logic              rst;
    logic              dispatch_valid;
    rob_pkg::regnm_t   dispatch_regnm;
    rob_pkg::op_kind_t dispatch_kind;
    logic              dispatch_predicted;
    logic              dispatch_en;
    logic [TAG_W-1:0]  dispatch_tag;
    logic              full;
    logic              ex_en;
    logic [TAG_W-1:0]  ex_tag;
    rob_pkg::data_t    ex_data;
    logic              ex_taken;
    rob_pkg::addr_t    ex_target;
    logic              lsb_en;
    logic [TAG_W-1:0]  lsb_tag;
    rob_pkg::data_t    lsb_data;
    rob_pkg::regnm_t   src_regnm;
    logic              src_busy;
    logic [TAG_W-1:0]  src_tag;
    logic              rf_we;
    rob_pkg::regnm_t   rf_regnm;
    rob_pkg::data_t    rf_data;
    logic [TAG_W-1:0]  rf_tag;
    logic              store_commit_en;
    logic [TAG_W-1:0]  store_commit_tag;
    logic              redirect_en;
    rob_pkg::addr_t    redirect_pc;

    integer seed;
    int     sweep_left;
    bit     saw_full;
    bit     saw_blocked;
    bit     saw_store;
    bit     saw_redirect;
    bit     head_ready;

    `include "rob_model.svh"

    rob_top #(.ROB_DEPTH(ROB_DEPTH)) rob_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual));
        end
    endtask

    // plays fetch/decode, execute and the load/store buffer for one cycle
    task automatic apply_stimulus(bit disp_on, bit wb_on);
        int i;
        int j;
        int pick;
        @(negedge clk);
        ex_en          = 1'b0;
        lsb_en         = 1'b0;
        dispatch_valid = 1'b0;
        if (wb_on && pending_q.size() != 0) begin
            i = int'($unsigned($random(seed)) % pending_q.size());
            j = int'($unsigned($random(seed)) % pending_q.size());
            if (!pending_q[i].done && pending_q[i].kind != rob_pkg::OP_STORE) begin
                ex_en     = 1'b1;
                ex_tag    = pending_q[i].tag;
                ex_data   = $random(seed);
                ex_taken  = 1'($random(seed));
                ex_target = $random(seed) & 32'hffff_fffc;
                record_result(i, ex_data, ex_taken, ex_target);
            end
            // loads come back through the lsb port
            if (j != i && !pending_q[j].done && pending_q[j].kind == rob_pkg::OP_ALU) begin
                lsb_en   = 1'b1;
                lsb_tag  = pending_q[j].tag;
                lsb_data = $random(seed);
                record_result(j, lsb_data, 1'b0, '0);
            end
        end
        if (sweep_left > 0) begin
            src_regnm  = 5'(rob_pkg::REG_COUNT - sweep_left);
            sweep_left = sweep_left - 1;
        end else begin
            src_regnm = 5'($random(seed));
            if (disp_on && ($random(seed) & 3) != 0) begin
                pick               = int'($unsigned($random(seed)) % 4);
                dispatch_valid     = 1'b1;
                dispatch_predicted = 1'($random(seed));
                dispatch_regnm     = 5'($random(seed));
                case (pick)
                    2:       dispatch_kind = rob_pkg::OP_BRANCH;
                    3:       dispatch_kind = rob_pkg::OP_STORE;
                    default: dispatch_kind = rob_pkg::OP_ALU;
                endcase
                if (dispatch_kind == rob_pkg::OP_STORE) begin
                    dispatch_regnm = '0;
                end
            end
        end
        #1;
        check_value("dispatch_en", 32'(dispatch_en),
                    32'(dispatch_valid && pending_q.size() < ROB_DEPTH));
        if (dispatch_valid && pending_q.size() == ROB_DEPTH) begin
            saw_blocked = 1'b1;
        end
        if (dispatch_en) begin
            check_value("dispatch_tag", 32'(dispatch_tag), 32'(next_tag));
            record_dispatch(dispatch_regnm, dispatch_kind, dispatch_predicted);
        end
    endtask

    task automatic compare_outputs();
        exp_entry_t e;
        // a head that was ready at the last edge commits at this one
        check_value("rf_we | store_commit_en", 32'(rf_we || store_commit_en),
                    32'(head_ready));
        if (rf_we || store_commit_en) begin
            if (pending_q.size() == 0) begin
                abort_run("a commit appeared while no entry was in flight");
            end else begin
                e = pending_q.pop_front();
                check_value("rf_we", 32'(rf_we), 32'(e.kind != rob_pkg::OP_STORE));
                check_value("store_commit_en", 32'(store_commit_en),
                            32'(e.kind == rob_pkg::OP_STORE));
                if (e.kind == rob_pkg::OP_STORE) begin
                    check_value("store_commit_tag", 32'(store_commit_tag), 32'(e.tag));
                    saw_store = 1'b1;
                end else begin
                    if (!e.done) begin
                        abort_run("an entry committed before its result was written back");
                    end
                    check_value("rf_regnm", 32'(rf_regnm), 32'(e.regnm));
                    check_value("rf_data", rf_data, e.data);
                    check_value("rf_tag", 32'(rf_tag), 32'(e.tag));
                end
                check_value("redirect_en", 32'(redirect_en), 32'(expect_redirect(e)));
                retire_entry(e);
                if (expect_redirect(e)) begin
                    check_value("redirect_pc", redirect_pc, e.target);
                    check_value("dispatch_tag", 32'(dispatch_tag), 32'(next_tag));
                    sweep_left   = rob_pkg::REG_COUNT;
                    saw_redirect = 1'b1;
                end
            end
        end else begin
            check_value("redirect_en", 32'(redirect_en), 32'd0);
        end
        check_value("full", 32'(full), 32'(pending_q.size() == ROB_DEPTH));
        if (full) begin
            saw_full = 1'b1;
        end
        check_value("src_busy", 32'(src_busy), 32'(busy_m[src_regnm]));
        if (busy_m[src_regnm]) begin
            check_value("src_tag", 32'(src_tag), 32'(owner_m[src_regnm]));
        end
        // stores leave without a result
        head_ready = (pending_q.size() != 0)
                     && (pending_q[0].done || pending_q[0].kind == rob_pkg::OP_STORE);
    endtask

    // registered outputs settle just after the rising edge
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (!rst) begin
                compare_outputs();
            end
        end
    end

    initial begin
        int cyc;
        int waited;
        seed               = 9830;
        sweep_left         = 0;
        saw_full           = 1'b0;
        saw_blocked        = 1'b0;
        saw_store          = 1'b0;
        saw_redirect       = 1'b0;
        head_ready         = 1'b0;
        reset_model();
        rst                = 1'b1;
        dispatch_valid     = 1'b0;
        dispatch_regnm     = '0;
        dispatch_kind      = rob_pkg::OP_ALU;
        dispatch_predicted = 1'b0;
        ex_en              = 1'b0;
        ex_tag             = '0;
        ex_data            = '0;
        ex_taken           = 1'b0;
        ex_target          = '0;
        lsb_en             = 1'b0;
        lsb_tag            = '0;
        lsb_data           = '0;
        src_regnm          = '0;
        repeat (2) @(negedge clk);
        check_value("full", 32'(full), 32'd0);
        check_value("rf_we", 32'(rf_we), 32'd0);
        check_value("store_commit_en", 32'(store_commit_en), 32'd0);
        check_value("redirect_en", 32'(redirect_en), 32'd0);
        rst = 1'b0;
        for (cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            // results held back at the start of each block so the buffer fills up
            apply_stimulus(1'b1, (cyc % 300) >= 60);
        end
        waited = 0;
        while (pending_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                abort_run("timed out waiting for the buffer to drain");
            end
            apply_stimulus(1'b0, 1'b1);
            waited = waited + 1;
        end
        if (!(saw_full && saw_blocked && saw_store && saw_redirect)) begin
            abort_run("the run never reached a full buffer, a store and a redirect");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+test
design/rob_pkg.sv
design/rob_if.sv
design/rob_ctrl.sv
design/rob_entry_file.sv
design/rename_table.sv
design/rob_top.sv
test/tb_rob.sv

/* run.sh */
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_rob -o tb_rob || exit 1
out=$(./obj_dir/tb_rob 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Test completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
